// ==== list.f ====
pwm_pkg.sv
bus_pkg.sv
reg_decoder.sv
pwm_control_unit.sv
timebase_generator.sv
pwm_chain.sv
sync_engine.sv
pwm_generator.sv
pwm_generator_asserts.sv
tb_pwm_generator.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_pwm_generator -f list.f -o sim_pwm_generator
./obj_dir/sim_pwm_generator

// ==== tb_pwm_generator.sv ====
/* Testbench for the PWM generator.
   Register readback, unmapped access, duty, fault override and sync timing */
module tb_pwm_generator;

    logic clock;
    logic reset;
    bus_pkg::bus_req_t bus_req;
    logic bus_valid;
    logic bus_ready;
    bus_pkg::bus_rsp_t bus_rsp;
    logic bus_rsp_valid;
    logic fault;
    logic timebase;
    pwm_pkg::pwm_vec_t pwm_out;
    logic sync_out;

    // Values the assertions compare against
    pwm_pkg::pwm_vec_t stopped_shadow;
    logic stop_check;
    logic run_check;
    logic sync_check;
    int sync_gap;
    int cycle;

    pwm_generator dut (.*);

    bind pwm_generator pwm_generator_asserts asserts (
        .clock(clock), .reset(reset), .bus_valid(bus_valid), .bus_ready(bus_ready),
        .bus_rsp_valid(bus_rsp_valid), .fault(fault), .timebase(timebase), .pwm_out(pwm_out),
        .sync_out(sync_out), .stopped_shadow(tb_pwm_generator.stopped_shadow),
        .stop_check(tb_pwm_generator.stop_check), .run_check(tb_pwm_generator.run_check),
        .sync_check(tb_pwm_generator.sync_check), .sync_gap(tb_pwm_generator.sync_gap)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    // Run time is bounded well above the longest test sequence
    initial begin
        repeat (20000) @(posedge clock);
        $display("Watchdog expired before the tests completed");
        $display("Checks failed");
        $fatal(1, "timeout");
    end

    // A failed assertion in the bound checker ends the run at once
    always @(posedge clock) begin
        if (dut.asserts.failures != 0) begin
            $display("Checks failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch");
        end
    endtask

    // One bus transfer, returns the response and the cycle it was accepted in
    task automatic bus_access(input logic write, input bus_pkg::reg_addr_t addr,
                              input bus_pkg::reg_data_t wdata,
                              output bus_pkg::reg_data_t rdata, output logic err,
                              output int accept_cycle);
        @(posedge clock);
        bus_req <= '{write: write, addr: addr, wdata: wdata};
        bus_valid <= 1'b1;
        @(posedge clock);
        while (!bus_ready) @(posedge clock);
        accept_cycle = cycle;
        bus_valid <= 1'b0;
        @(posedge clock);
        check_value("bus_rsp_valid", 32'd1, 32'(bus_rsp_valid));
        rdata = bus_rsp.rdata;
        err = bus_rsp.err;
    endtask

    task automatic bus_write(input bus_pkg::reg_addr_t addr, input bus_pkg::reg_data_t wdata);
        bus_pkg::reg_data_t rdata;
        logic err;
        int accepted;
        bus_access(1'b1, addr, wdata, rdata, err, accepted);
        check_value("write_err", 32'd0, 32'(err));
    endtask

    task automatic bus_read(input string name, input bus_pkg::reg_addr_t addr,
                            input logic [31:0] expected, input logic expect_err);
        bus_pkg::reg_data_t rdata;
        logic err;
        int accepted;
        bus_access(1'b0, addr, '0, rdata, err, accepted);
        check_value({name, "_err"}, 32'(expect_err), 32'(err));
        if (!expect_err) begin
            check_value(name, expected, rdata);
        end
    endtask

    // Count cycles with an a output high over one full period
    task automatic count_duty(input int bit_index, input int period, input int compare);
        int high;
        high = 0;
        repeat (period + 1) begin
            @(posedge clock);
            if (pwm_out[bit_index]) high++;
        end
        check_value("duty", 32'(compare), 32'(high));
    endtask

    initial begin
        bus_pkg::reg_addr_t addrs [11];
        logic [31:0] masks [11];
        logic [31:0] values [11];
        bus_pkg::reg_addr_t base;
        bus_pkg::reg_data_t rdata;
        logic err;
        int run_cycle;
        int periods [pwm_pkg::n_chains];
        int compares [pwm_pkg::n_chains][pwm_pkg::n_channels];
        int delay;
        int sync_cycle;
        void'($urandom(32'h7e9e));
        cycle = 0;
        reset = 1'b1;
        bus_req = '0;
        bus_valid = 1'b0;
        fault = 1'b0;
        stopped_shadow = '0;
        stop_check = 1'b0;
        run_check = 1'b0;
        sync_check = 1'b0;
        sync_gap = 0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // Control registers, then period and compares of each chain
        addrs[0] = bus_pkg::ctrl_base + 12'(bus_pkg::reg_run);
        addrs[1] = bus_pkg::ctrl_base + 12'(bus_pkg::reg_divider);
        addrs[2] = bus_pkg::ctrl_base + 12'(bus_pkg::reg_stopped);
        addrs[3] = bus_pkg::ctrl_base + 12'(bus_pkg::reg_sync_select);
        addrs[4] = bus_pkg::ctrl_base + 12'(bus_pkg::reg_sync_delay);
        masks[0] = 32'h1;
        masks[1] = 32'h7;
        masks[2] = 32'hff;
        masks[3] = 32'h1;
        masks[4] = 32'hffff;
        for (int i = 0; i < pwm_pkg::n_chains; i++) begin
            base = bus_pkg::ctrl_base + bus_pkg::region_size * 12'(i + 1);
            for (int r = 0; r < 3; r++) begin
                addrs[5 + 3 * i + r] = base + 12'(4 * r);
                masks[5 + 3 * i + r] = 32'hffff;
            end
        end

        // Run is checked and cleared before the other registers so the chains and sync stay idle
        values[0] = $urandom;
        bus_write(addrs[0], values[0]);
        bus_read("readback", addrs[0], values[0] & masks[0], 1'b0);
        bus_write(addrs[0], 32'h0);
        for (int n = 1; n < 11; n++) begin
            values[n] = $urandom;
            bus_write(addrs[n], values[n]);
        end
        for (int n = 1; n < 11; n++) begin
            bus_read("readback", addrs[n], values[n] & masks[n], 1'b0);
        end

        // Unmapped region and unused offsets in the control unit and a chain
        bus_read("unmapped_region", 12'h300, '0, 1'b1);
        bus_read("unused_ctrl_offset", 12'h014, '0, 1'b1);
        bus_read("unused_chain_offset", 12'h10c, '0, 1'b1);

        // Stopped: outputs hold the programmed safe state
        bus_write(12'h000, 32'h0);
        stopped_shadow = pwm_pkg::pwm_vec_t'($urandom);
        bus_write(12'h008, 32'(stopped_shadow));
        stop_check = 1'b1;
        repeat (20) @(posedge clock);

        // Program periods, compares and the sync source
        for (int i = 0; i < pwm_pkg::n_chains; i++) begin
            periods[i] = 10 + $urandom % 30;
            base = bus_pkg::region_size * 12'(i + 1);
            bus_write(base, 32'(periods[i]));
            for (int k = 0; k < pwm_pkg::n_channels; k++) begin
                compares[i][k] = $urandom % (periods[i] + 2);
                bus_write(base + 12'(4 + 4 * k), 32'(compares[i][k]));
            end
        end
        delay = $urandom % periods[0];
        bus_write(12'h004, 32'h0);
        bus_write(12'h00c, 32'h0);
        bus_write(12'h010, 32'(delay));

        // Start running and predict the first sync pulse from chain 0
        stop_check = 1'b0;
        bus_access(1'b1, 12'h000, 32'h1, rdata, err, run_cycle);
        check_value("run_err", 32'd0, 32'(err));
        run_check = 1'b1;
        do @(posedge clock); while (!sync_out);
        sync_cycle = cycle;
        check_value("sync_first", 32'(periods[0] + delay + 2), 32'(sync_cycle - run_cycle));
        sync_gap <= periods[0] + 1;
        sync_check <= 1'b1;
        repeat (3) begin
            do @(posedge clock); while (!sync_out);
        end

        // Each a output is high for its compare count every period
        for (int i = 0; i < pwm_pkg::n_chains; i++) begin
            for (int k = 0; k < pwm_pkg::n_channels; k++) begin
                count_duty(i * pwm_pkg::n_channels + k, periods[i], compares[i][k]);
            end
        end

        // Fault forces the safe state while running
        @(posedge clock);
        fault <= 1'b1;
        repeat (15) @(posedge clock);
        fault <= 1'b0;
        repeat (5) @(posedge clock);

        // Stop again and watch the safe state return
        sync_check <= 1'b0;
        run_check = 1'b0;
        bus_write(12'h000, 32'h0);
        stop_check = 1'b1;
        repeat (20) @(posedge clock);

        if (dut.asserts.failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// ==== pwm_generator_asserts.sv ====
/* Assertions bound to the PWM generator top level.
   Check bus response timing, safe-state gating, timebase, complementary outputs and sync spacing */
module pwm_generator_asserts (
    input logic              clock,
    input logic              reset,
    input logic              bus_valid,
    input logic              bus_ready,
    input logic              bus_rsp_valid,
    input logic              fault,
    input logic              timebase,
    input pwm_pkg::pwm_vec_t pwm_out,
    input logic              sync_out,
    input pwm_pkg::pwm_vec_t stopped_shadow,
    input logic              stop_check,
    input logic              run_check,
    input logic              sync_check,
    input int                sync_gap
);

    localparam int half = pwm_pkg::n_pwm / 2;

    // Cycles since the last sync pulse
    int since;
    // Set once a sync pulse has been seen while checking is enabled
    logic sync_seen;
    // Number of assertions that have failed so far
    int failures = 0;

    always_ff @(posedge clock) begin
        if (reset || !sync_check) begin
            since <= 0;
            sync_seen <= 1'b0;
        end else if (sync_out) begin
            since <= 1;
            sync_seen <= 1'b1;
        end else begin
            since <= since + 1;
        end
    end

    // A response follows every accepted request after exactly one cycle
    rsp_after_accept: assert property (@(posedge clock) disable iff (reset)
        (bus_valid && bus_ready) |=> bus_rsp_valid)
        else begin
            failures++;
            $error("no response one cycle after an accepted request");
        end

    // And no response appears without a request one cycle before
    rsp_only_after_accept: assert property (@(posedge clock) disable iff (reset)
        bus_rsp_valid |-> $past(bus_valid && bus_ready))
        else begin
            failures++;
            $error("response without an accepted request one cycle before");
        end

    // Fault or a stopped generator drives the safe state
    safe_state: assert property (@(posedge clock) disable iff (reset)
        (fault || stop_check) |-> pwm_out == stopped_shadow)
        else begin
            failures++;
            $error("outputs differ from the programmed safe state");
        end

    // A zero divider ticks on every running cycle and a stopped generator never ticks
    timebase_rate: assert property (@(posedge clock) disable iff (reset)
        (run_check || stop_check) |-> timebase == run_check)
        else begin
            failures++;
            $error("timebase does not follow the run state");
        end

    // The b half mirrors the a half while running
    complementary: assert property (@(posedge clock) disable iff (reset)
        (run_check && !fault) |-> pwm_out[half +: half] == ~pwm_out[0 +: half])
        else begin
            failures++;
            $error("b outputs are not the inverse of the a outputs");
        end

    // Successive sync pulses are one PWM period apart
    sync_spacing: assert property (@(posedge clock) disable iff (reset)
        (sync_out && sync_seen && sync_check) |-> since == sync_gap)
        else begin
            failures++;
            $error("sync pulses are not one period apart");
        end

endmodule

// ==== pwm_generator.sv ====
/* Multi-channel PWM generator top level.
   Connects the bus decoder, control unit, timebase, chains and sync engine */
module pwm_generator (
    input  logic              clock,
    input  logic              reset,
    input  bus_pkg::bus_req_t bus_req,
    input  logic              bus_valid,
    output logic              bus_ready,
    output bus_pkg::bus_rsp_t bus_rsp,
    output logic              bus_rsp_valid,
    input  logic              fault,
    output logic              timebase,
    output pwm_pkg::pwm_vec_t pwm_out,
    output logic              sync_out
);

    bus_pkg::bus_req_t slave_req;
    logic [pwm_pkg::n_chains:0] slave_valid;
    bus_pkg::bus_rsp_t slave_rsp [pwm_pkg::n_chains + 1];
    pwm_pkg::pwm_ctrl_t ctrl;
    logic tick;
    logic [pwm_pkg::n_chains-1:0] wrap;
    logic [pwm_pkg::n_channels-1:0] chain_a [pwm_pkg::n_chains];
    logic [pwm_pkg::n_channels-1:0] chain_b [pwm_pkg::n_chains];
    pwm_pkg::pwm_vec_t chain_pwm;

    reg_decoder decoder (
        .clock(clock), .reset(reset),
        .bus_req(bus_req), .bus_valid(bus_valid), .bus_ready(bus_ready),
        .bus_rsp(bus_rsp), .bus_rsp_valid(bus_rsp_valid),
        .slave_req(slave_req), .slave_valid(slave_valid), .slave_rsp(slave_rsp)
    );

    // Slave 0 is the control unit
    pwm_control_unit control (
        .clock(clock), .reset(reset), .req(slave_req), .valid(slave_valid[0]),
        .rsp(slave_rsp[0]), .ctrl(ctrl)
    );

    timebase_generator timebase_gen (
        .clock(clock), .reset(reset), .run(ctrl.run), .divider(ctrl.divider), .tick(tick)
    );

    // Chain i answers as slave i + 1
    for (genvar i = 0; i < pwm_pkg::n_chains; i++) begin : g_chain
        pwm_chain chain (
            .clock(clock), .reset(reset), .req(slave_req), .valid(slave_valid[i + 1]),
            .rsp(slave_rsp[i + 1]), .run(ctrl.run), .tick(tick), .wrap(wrap[i]),
            .out_a(chain_a[i]), .out_b(chain_b[i])
        );
    end

    sync_engine sync (
        .clock(clock), .reset(reset), .wrap_in(wrap), .sync_select(ctrl.sync_select),
        .sync_delay(ctrl.sync_delay), .sync_out(sync_out)
    );

    // All a outputs first, chain by chain, then all b outputs
    always_comb begin
        for (int j = 0; j < pwm_pkg::n_chains; j++) begin
            chain_pwm[j * pwm_pkg::n_channels +: pwm_pkg::n_channels] = chain_a[j];
            chain_pwm[(pwm_pkg::n_chains + j) * pwm_pkg::n_channels +: pwm_pkg::n_channels] =
                chain_b[j];
        end
    end

    // A fault or a stopped generator forces the safe state at once
    assign pwm_out = (ctrl.run && !fault) ? chain_pwm : ctrl.stopped_state;
    assign timebase = tick;

endmodule

// ==== sync_engine.sv ====
/* Sync pulse engine.
   Re-emits the selected chain's wrap pulse after a programmed delay */
module sync_engine (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [pwm_pkg::n_chains-1:0]  wrap_in,
    input  pwm_pkg::chain_sel_t           sync_select,
    input  pwm_pkg::delay_t               sync_delay,
    output logic                          sync_out
);

    logic wrap_sel;
    // Set while a delayed pulse is waiting to go out
    logic pending;
    pwm_pkg::delay_t remaining;

    assign wrap_sel = wrap_in[sync_select];

    // The pulse leaves in the cycle the countdown reaches zero,
    // which is sync_delay + 1 cycles after the wrap
    assign sync_out = pending && (remaining == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
            remaining <= '0;
        end else if (pending) begin
            // Wraps arriving now are dropped, only one pulse is in flight
            if (remaining == '0) begin
                pending <= 1'b0;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end else if (wrap_sel) begin
            pending <= 1'b1;
            remaining <= sync_delay;
        end
    end

endmodule

// ==== pwm_chain.sv ====
/* One PWM chain.
   Period and compare registers, a period counter and complementary outputs */
module pwm_chain (
    input  logic              clock,
    input  logic              reset,
    input  bus_pkg::bus_req_t req,
    input  logic              valid,
    output bus_pkg::bus_rsp_t rsp,
    input  logic              run,
    input  logic              tick,
    output logic              wrap,
    output logic [pwm_pkg::n_channels-1:0] out_a,
    output logic [pwm_pkg::n_channels-1:0] out_b
);

    bus_pkg::reg_offset_t offset;
    bus_pkg::reg_data_t rd_data;
    logic hit;
    pwm_pkg::counter_t period;
    pwm_pkg::counter_t compare [pwm_pkg::n_channels];
    pwm_pkg::counter_t count;

    assign offset = bus_pkg::reg_offset_t'(req.addr);

    // Period sits at offset zero, compare k four bytes further per channel
    always_comb begin
        hit = 1'b0;
        rd_data = '0;
        if (offset == bus_pkg::reg_period) begin
            hit = 1'b1;
            rd_data = bus_pkg::reg_data_t'(period);
        end
        for (int k = 0; k < pwm_pkg::n_channels; k++) begin
            if (offset == bus_pkg::reg_offset_t'(bus_pkg::reg_compare + 4 * k)) begin
                hit = 1'b1;
                rd_data = bus_pkg::reg_data_t'(compare[k]);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            period <= '0;
            for (int k = 0; k < pwm_pkg::n_channels; k++) begin
                compare[k] <= '0;
            end
            rsp <= '0;
        end else begin
            rsp <= '0;
            if (valid) begin
                rsp.err <= !hit;
                if (!req.write) begin
                    rsp.rdata <= rd_data;
                end else begin
                    if (offset == bus_pkg::reg_period) begin
                        period <= pwm_pkg::counter_t'(req.wdata);
                    end
                    for (int k = 0; k < pwm_pkg::n_channels; k++) begin
                        if (offset == bus_pkg::reg_offset_t'(bus_pkg::reg_compare + 4 * k)) begin
                            compare[k] <= pwm_pkg::counter_t'(req.wdata);
                        end
                    end
                end
            end
        end
    end

    // The tick that takes the count from period back to zero
    assign wrap = tick && (count == period);

    // b is always the inverse of a, so the pair never overlaps
    assign out_b = ~out_a;

    always_ff @(posedge clock) begin
        if (reset || !run) begin
            count <= '0;
            out_a <= '0;
        end else begin
            if (tick) begin
                count <= wrap ? '0 : count + 1'b1;
            end
            // Outputs follow the count by one cycle
            for (int k = 0; k < pwm_pkg::n_channels; k++) begin
                out_a[k] <= count < compare[k];
            end
        end
    end

endmodule

// ==== timebase_generator.sv ====
/* Timebase divider.
   Emits one tick every 2^divider clock cycles while the generator runs */
module timebase_generator (
    input  logic              clock,
    input  logic              reset,
    input  logic              run,
    input  pwm_pkg::divider_t divider,
    output logic              tick
);

    // The largest divider needs a count up to 2^7 - 1
    logic [(1 << $bits(pwm_pkg::divider_t)) - 2:0] div_count;
    logic [(1 << $bits(pwm_pkg::divider_t)) - 2:0] div_mask;

    // Terminal count is 2^divider - 1, zero when the divider is zero
    assign div_mask = '1 >> ($bits(div_mask) - divider);

    // With a zero divider the count stays at zero and every cycle ticks
    assign tick = run && (div_count == div_mask);

    always_ff @(posedge clock) begin
        if (reset) begin
            div_count <= '0;
        end else if (!run || tick) begin
            // Restart the period on each tick and hold it clear while stopped
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

endmodule

// ==== pwm_control_unit.sv ====
/* Global control registers of the PWM generator.
   Holds run, divider, stopped state and the sync settings */
module pwm_control_unit (
    input  logic               clock,
    input  logic               reset,
    input  bus_pkg::bus_req_t  req,
    input  logic               valid,
    output bus_pkg::bus_rsp_t  rsp,
    output pwm_pkg::pwm_ctrl_t ctrl
);

    bus_pkg::reg_offset_t offset;
    bus_pkg::reg_data_t rd_data;
    logic hit;

    // Each region spans 256 bytes, so the low byte is the register offset
    assign offset = bus_pkg::reg_offset_t'(req.addr);

    // Read data is zero-extended from the field width
    always_comb begin
        hit = 1'b1;
        rd_data = '0;
        case (offset)
            bus_pkg::reg_run:         rd_data = bus_pkg::reg_data_t'(ctrl.run);
            bus_pkg::reg_divider:     rd_data = bus_pkg::reg_data_t'(ctrl.divider);
            bus_pkg::reg_stopped:     rd_data = bus_pkg::reg_data_t'(ctrl.stopped_state);
            bus_pkg::reg_sync_select: rd_data = bus_pkg::reg_data_t'(ctrl.sync_select);
            bus_pkg::reg_sync_delay:  rd_data = bus_pkg::reg_data_t'(ctrl.sync_delay);
            default:                  hit = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Everything zero, so the generator starts stopped
            ctrl <= '0;
            rsp <= '0;
        end else begin
            rsp <= '0;
            if (valid) begin
                rsp.err <= !hit;
                if (!req.write) begin
                    rsp.rdata <= rd_data;
                end else begin
                    // Writes keep only the bits that fit the field
                    case (offset)
                        bus_pkg::reg_run:         ctrl.run <= req.wdata[0];
                        bus_pkg::reg_divider:     ctrl.divider <= pwm_pkg::divider_t'(req.wdata);
                        bus_pkg::reg_stopped:     ctrl.stopped_state <= pwm_pkg::pwm_vec_t'(req.wdata);
                        bus_pkg::reg_sync_select: ctrl.sync_select <= pwm_pkg::chain_sel_t'(req.wdata);
                        bus_pkg::reg_sync_delay:  ctrl.sync_delay <= pwm_pkg::delay_t'(req.wdata);
                        default:                  ;
                    endcase
                end
            end
        end
    end

endmodule

// ==== reg_decoder.sv ====
/* Register bus address decoder.
   Routes requests to the control unit or a chain and muxes the answer back */
module reg_decoder (
    input  logic              clock,
    input  logic              reset,
    input  bus_pkg::bus_req_t bus_req,
    input  logic              bus_valid,
    output logic              bus_ready,
    output bus_pkg::bus_rsp_t bus_rsp,
    output logic              bus_rsp_valid,
    output bus_pkg::bus_req_t slave_req,
    output logic [pwm_pkg::n_chains:0] slave_valid,
    input  bus_pkg::bus_rsp_t slave_rsp [pwm_pkg::n_chains + 1]
);

    logic accept;
    bus_pkg::reg_addr_t region;
    logic mapped;
    // Region of the request in flight, used to pick its response
    logic [$clog2(pwm_pkg::n_chains + 1)-1:0] sel_q;
    logic miss_q;

    assign accept = bus_valid && bus_ready;

    // Region 0 is the control unit, region i + 1 is chain i
    assign region = (bus_req.addr - bus_pkg::ctrl_base) / bus_pkg::region_size;
    assign mapped = region < bus_pkg::reg_addr_t'(pwm_pkg::n_chains + 1);

    // All slaves see the same request, only the selected one gets valid
    assign slave_req = bus_req;

    always_comb begin
        slave_valid = '0;
        if (accept && mapped) begin
            slave_valid[region[$bits(sel_q)-1:0]] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bus_ready <= 1'b1;
            bus_rsp_valid <= 1'b0;
            sel_q <= '0;
            miss_q <= 1'b0;
        end else begin
            // Drop ready for one cycle so only one request is in flight
            bus_ready <= !accept;
            bus_rsp_valid <= accept;
            if (accept) begin
                sel_q <= mapped ? region[$bits(sel_q)-1:0] : '0;
                miss_q <= !mapped;
            end
        end
    end

    // An access outside every region is answered here with err set
    always_comb begin
        if (miss_q) begin
            bus_rsp = '{rdata: '0, err: 1'b1};
        end else begin
            bus_rsp = slave_rsp[sel_q];
        end
    end

endmodule

// ==== bus_pkg.sv ====
/* Register bus definitions.
   Request and response records, address and data types, and the address map */
package bus_pkg;

    // Byte address covering the control region and every chain region
    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Offset of a register inside its own region
    typedef logic [7:0] reg_offset_t;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } bus_req_t;

    // A write answers with zero data, err flags an unmapped access
    typedef struct packed {
        reg_data_t rdata;
        logic      err;
    } bus_rsp_t;

    // Control block first, then chain i at ctrl_base + region_size * (i + 1)
    localparam reg_addr_t region_size = 12'h100;
    localparam reg_addr_t ctrl_base = 12'h000;

    // Control unit registers
    localparam reg_offset_t reg_run = 8'h00;
    localparam reg_offset_t reg_divider = 8'h04;
    localparam reg_offset_t reg_stopped = 8'h08;
    localparam reg_offset_t reg_sync_select = 8'h0C;
    localparam reg_offset_t reg_sync_delay = 8'h10;

    // Chain registers, compare k sits at reg_compare + 4k
    localparam reg_offset_t reg_period = 8'h00;
    localparam reg_offset_t reg_compare = 8'h04;

endpackage

// ==== pwm_pkg.sv ====
/* PWM-side definitions shared by the generator blocks.
   Chain and channel counts, counter widths and the global control record */
package pwm_pkg;

    // Two chains, each with two channel pairs
    localparam int n_chains = 2;
    localparam int n_channels = 2;

    // Every channel drives an a output and its complementary b output
    localparam int n_pwm = 2 * n_chains * n_channels;

    localparam int counter_width = 16;

    // Counts, periods and compare thresholds all share this width
    typedef logic [counter_width-1:0] counter_t;

    // The timebase divides the clock by 2^divider
    typedef logic [2:0] divider_t;

    // One bit per output pin
    typedef logic [n_pwm-1:0] pwm_vec_t;

    // Index of a chain, used to pick the sync source
    typedef logic [$clog2(n_chains)-1:0] chain_sel_t;

    // Sync delay measured in clock cycles
    typedef logic [15:0] delay_t;

    // Global settings held by the control unit
    typedef struct packed {
        logic       run;
        divider_t   divider;
        pwm_vec_t   stopped_state;
        chain_sel_t sync_select;
        delay_t     sync_delay;
    } pwm_ctrl_t;

endpackage
